// File: Bender.yml
package:
  name: read_port

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/read_port_pkg.sv
      - hdl/queue_if.sv
      - hdl/priority_queues.sv
      - hdl/packet_buffer.sv
      - hdl/read_arbiter.sv
      - hdl/read_port_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/read_port_assert.sv
      - sim/read_port_tb.sv

// File: hdl/packet_buffer.sv
// shared word memory, one write port and one registered read port
`timescale 1ns/1ns
`include "read_port_macros.svh"

module packet_buffer (
    input  logic                  clk,
    input  logic                  wr_en,
    input  read_port_pkg::addr_t  wr_addr,
    input  read_port_pkg::word_t  wr_data,
    input  logic                  rd_en,
    input  read_port_pkg::addr_t  rd_addr,
    output read_port_pkg::word_t  rd_data
);

    localparam int DEPTH = `NUM_PRIO * `PRIO_DEPTH;

    read_port_pkg::word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // data shows up the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hdl/priority_queues.sv
// per-priority circular pointers, word and packet counts, prepared flags
`timescale 1ns/1ns
`include "read_port_macros.svh"

module priority_queues (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enq_valid,
    input  read_port_pkg::prio_t  enq_prio,
    input  logic                  enq_last,
    output logic                  enq_ready,
    output logic                  wr_en,
    output read_port_pkg::addr_t  wr_addr,
    queue_if.queue_side           q
);

    localparam int PTR_W = $clog2(`PRIO_DEPTH);
    localparam int CNT_W = $clog2(`PRIO_DEPTH + 1);

    logic [PTR_W-1:0] head_ptr [`NUM_PRIO];
    logic [PTR_W-1:0] tail_ptr [`NUM_PRIO];
    logic [CNT_W-1:0] word_cnt [`NUM_PRIO];
    logic [CNT_W-1:0] pkt_cnt  [`NUM_PRIO];
    // end-of-packet marker per stored word
    logic             last_flag [`NUM_PRIO][`PRIO_DEPTH];

    logic                 ready_q;
    logic [`NUM_PRIO-1:0] push_hit;
    logic [`NUM_PRIO-1:0] pop_hit;

    // region full stalls only that priority
    assign enq_ready = ready_q && (word_cnt[enq_prio] != CNT_W'(`PRIO_DEPTH));
    assign wr_en     = enq_valid && enq_ready;

    // region base is prio * PRIO_DEPTH, so the prio lands in the top bits
    assign wr_addr   = {enq_prio, tail_ptr[enq_prio]};
    assign q.rd_addr = {q.pop_prio, head_ptr[q.pop_prio]};
    assign q.rd_last = last_flag[q.pop_prio][head_ptr[q.pop_prio]];

    always_comb begin
        for (int i = 0; i < `NUM_PRIO; i++) begin
            push_hit[i]   = wr_en && (enq_prio == read_port_pkg::prio_t'(i));
            pop_hit[i]    = q.pop && (q.pop_prio == read_port_pkg::prio_t'(i));
            q.prepared[i] = (pkt_cnt[i] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
            for (int i = 0; i < `NUM_PRIO; i++) begin
                head_ptr[i] <= '0;
                tail_ptr[i] <= '0;
                word_cnt[i] <= '0;
                pkt_cnt[i]  <= '0;
            end
        end else begin
            ready_q <= 1'b1;
            for (int i = 0; i < `NUM_PRIO; i++) begin
                if (push_hit[i]) begin
                    tail_ptr[i] <= tail_ptr[i] + 1'b1;
                end
                if (pop_hit[i]) begin
                    head_ptr[i] <= head_ptr[i] + 1'b1;
                end
                word_cnt[i] <= word_cnt[i] + CNT_W'(push_hit[i]) - CNT_W'(pop_hit[i]);
                // packet counts on last word in and last word out
                pkt_cnt[i] <= pkt_cnt[i] + CNT_W'(push_hit[i] && enq_last)
                              - CNT_W'(pop_hit[i] && q.rd_last);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            last_flag[enq_prio][tail_ptr[enq_prio]] <= enq_last;
        end
    end

endmodule

// File: hdl/queue_if.sv
// interface between the priority queues and the read arbiter
`timescale 1ns/1ns
`include "read_port_macros.svh"

interface queue_if;

    // one bit per priority, high while a whole packet is stored
    logic [`NUM_PRIO-1:0]  prepared;
    logic                  pop;
    read_port_pkg::prio_t  pop_prio;
    // head of pop_prio, combinational
    read_port_pkg::addr_t  rd_addr;
    logic                  rd_last;

    modport queue_side (
        output prepared,
        output rd_addr,
        output rd_last,
        input  pop,
        input  pop_prio
    );

    modport arb_side (
        input  prepared,
        input  rd_addr,
        input  rd_last,
        output pop,
        output pop_prio
    );

endinterface

// File: hdl/read_arbiter.sv
// strict priority and wrr selection, credit counter, output framing
`timescale 1ns/1ns
`include "read_port_macros.svh"

module read_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  read_port_pkg::sched_mode_e  sched_mode,
    input  logic [`WEIGHT_W-1:0]        wrr_weight,
    input  logic                        credit_return,
    queue_if.arb_side                   q,
    output logic                        rd_en,
    input  read_port_pkg::word_t        rd_data,
    output logic                        out_valid,
    output logic                        out_sop,
    output logic                        out_eop,
    output read_port_pkg::prio_t        out_prio,
    output read_port_pkg::word_t        out_data
);

    localparam int CRED_W = $clog2(`MAX_CREDITS + 1);

    read_port_pkg::arb_state_e state;
    logic [CRED_W-1:0]         credit_cnt;
    logic                      have_credit;
    read_port_pkg::prio_t      gnt_prio;
    read_port_pkg::prio_t      cur_prio;
    logic [`WEIGHT_W-1:0]      run_cnt;
    logic [`WEIGHT_W-1:0]      weight_eff;
    logic                      first_word;
    read_port_pkg::prio_t      sp_prio;
    read_port_pkg::prio_t      wrr_next;
    logic                      wrr_stay;
    logic                      valid_q;
    logic                      sop_q;
    logic                      eop_q;
    read_port_pkg::prio_t      prio_q;

    assign have_credit = (credit_cnt != '0);
    assign q.pop       = (state == read_port_pkg::arb_stream) && have_credit;
    assign q.pop_prio  = gnt_prio;
    assign rd_en       = q.pop;

    // zero weight behaves as one
    assign weight_eff = (wrr_weight == '0) ? `WEIGHT_W'(1) : wrr_weight;
    assign wrr_stay   = q.prepared[cur_prio] && (run_cnt < weight_eff);

    always_comb begin
        read_port_pkg::prio_t cand;
        logic found;
        sp_prio  = '0;
        wrr_next = cur_prio;
        found    = 1'b0;
        for (int i = 0; i < `NUM_PRIO; i++) begin
            if (q.prepared[i]) begin
                sp_prio = read_port_pkg::prio_t'(i);
            end
        end
        // walk downward from the current priority, last step lands on itself
        for (int k = 1; k <= `NUM_PRIO; k++) begin
            cand = cur_prio - read_port_pkg::prio_t'(k);
            if (!found && q.prepared[cand]) begin
                wrr_next = cand;
                found    = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= '0;
        end else if (credit_return && !q.pop && credit_cnt < CRED_W'(`MAX_CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;
        end else if (q.pop && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= read_port_pkg::arb_idle;
            gnt_prio   <= '0;
            cur_prio   <= '0;
            run_cnt    <= '0;
            first_word <= 1'b0;
        end else begin
            case (state)
                read_port_pkg::arb_idle: begin
                    if (have_credit && (|q.prepared)) begin
                        state <= read_port_pkg::arb_select;
                    end
                end
                read_port_pkg::arb_select: begin
                    if (sched_mode == read_port_pkg::sched_sp) begin
                        gnt_prio <= sp_prio;
                    end else if (wrr_stay) begin
                        gnt_prio <= cur_prio;
                        run_cnt  <= run_cnt + 1'b1;
                    end else begin
                        gnt_prio <= wrr_next;
                        cur_prio <= wrr_next;
                        run_cnt  <= `WEIGHT_W'(1);
                    end
                    first_word <= 1'b1;
                    state      <= read_port_pkg::arb_stream;
                end
                read_port_pkg::arb_stream: begin
                    if (q.pop) begin
                        first_word <= 1'b0;
                        if (q.rd_last) begin
                            state <= read_port_pkg::arb_idle;
                        end
                    end
                end
                default: state <= read_port_pkg::arb_idle;
            endcase
        end
    end

    // framing follows the pop by the buffer's read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            sop_q   <= 1'b0;
            eop_q   <= 1'b0;
        end else begin
            valid_q <= q.pop;
            sop_q   <= q.pop && first_word;
            eop_q   <= q.pop && q.rd_last;
        end
    end

    always_ff @(posedge clk) begin
        prio_q <= gnt_prio;
    end

    assign out_valid = valid_q;
    assign out_sop   = sop_q;
    assign out_eop   = eop_q;
    assign out_prio  = prio_q;
    assign out_data  = rd_data;

endmodule

// File: hdl/read_port_macros.svh
// size macros for the packet switch read port
`ifndef READ_PORT_MACROS_SVH
`define READ_PORT_MACROS_SVH

// priority classes, one buffer region each
`define NUM_PRIO 8

// words per priority region
`define PRIO_DEPTH 16

// data word width
`define DATA_W 64

// 8 regions of 16 words
`define ADDR_W 7

`define WEIGHT_W 5

// credits the arbiter can bank from the sink
`define MAX_CREDITS 8

`endif

// File: hdl/read_port_pkg.sv
// package with word, address and priority types and the arbiter enums
`include "read_port_macros.svh"

package read_port_pkg;

    // one buffer word
    typedef logic [`DATA_W-1:0] word_t;

    // region index in the upper bits, slot in the lower bits
    typedef logic [`ADDR_W-1:0] addr_t;

    // higher value wins under strict priority
    typedef logic [$clog2(`NUM_PRIO)-1:0] prio_t;

    typedef enum logic {
        sched_sp,
        sched_wrr
    } sched_mode_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_select,
        arb_stream
    } arb_state_e;

endpackage

// File: hdl/read_port_top.sv
// read port top with priority queues, packet buffer and read arbiter
`timescale 1ns/1ns
`include "read_port_macros.svh"

module read_port_top (
    input  logic                        clk,
    input  logic                        rst,
    input  read_port_pkg::sched_mode_e  sched_mode,
    input  logic [`WEIGHT_W-1:0]        wrr_weight,
    input  logic                        enq_valid,
    input  read_port_pkg::prio_t        enq_prio,
    input  read_port_pkg::word_t        enq_data,
    input  logic                        enq_last,
    output logic                        enq_ready,
    input  logic                        credit_return,
    output logic                        out_valid,
    output logic                        out_sop,
    output logic                        out_eop,
    output read_port_pkg::prio_t        out_prio,
    output read_port_pkg::word_t        out_data
);

    logic                 wr_en;
    read_port_pkg::addr_t wr_addr;
    logic                 rd_en;
    read_port_pkg::word_t rd_data;

    queue_if qif ();

    priority_queues u_queues (
        .clk       (clk),
        .rst       (rst),
        .enq_valid (enq_valid),
        .enq_prio  (enq_prio),
        .enq_last  (enq_last),
        .enq_ready (enq_ready),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .q         (qif.queue_side)
    );

    // enqueue data goes straight to the slot the queues picked
    packet_buffer u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (enq_data),
        .rd_en   (rd_en),
        .rd_addr (qif.rd_addr),
        .rd_data (rd_data)
    );

    read_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .sched_mode    (sched_mode),
        .wrr_weight    (wrr_weight),
        .credit_return (credit_return),
        .q             (qif.arb_side),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .out_valid     (out_valid),
        .out_sop       (out_sop),
        .out_eop       (out_eop),
        .out_prio      (out_prio),
        .out_data      (out_data)
    );

endmodule

// File: read_port.f
+incdir+hdl
hdl/read_port_pkg.sv
hdl/queue_if.sv
hdl/priority_queues.sv
hdl/packet_buffer.sv
hdl/read_arbiter.sv
hdl/read_port_top.sv
sim/read_port_assert.sv
sim/read_port_tb.sv

// File: sim/read_port_assert.sv
// framing and credit assertions, bound into the read arbiter
`timescale 1ns/1ns
`include "read_port_macros.svh"

module read_port_assert #(
    parameter int CRED_W = 4
) (
    input logic              clk,
    input logic              rst,
    input logic              out_valid,
    input logic              out_sop,
    input logic              out_eop,
    input logic              credit_return,
    input logic              pop,
    input logic [CRED_W-1:0] credit_cnt
);

    int                fail_cnt = 0;
    logic              in_pkt;
    // credits returned by the sink less words read, capped at the bank size
    logic [CRED_W-1:0] held;

    // open packet between sop and eop
    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt <= 1'b0;
        end else if (out_valid && out_eop) begin
            in_pkt <= 1'b0;
        end else if (out_valid && out_sop) begin
            in_pkt <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else if (credit_return && !pop) begin
            if (held != CRED_W'(`MAX_CREDITS)) begin
                held <= held + 1'b1;
            end
        end else if (pop && !credit_return) begin
            held <= held - 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) out_sop |-> out_valid)
        else begin
            fail_cnt++;
            $error("out_sop raised without out_valid");
        end

    assert property (@(posedge clk) disable iff (rst) out_eop |-> out_valid)
        else begin
            fail_cnt++;
            $error("out_eop raised without out_valid");
        end

    assert property (@(posedge clk) disable iff (rst) (out_valid && out_sop) |-> !in_pkt)
        else begin
            fail_cnt++;
            $error("second sop before the eop of the open packet");
        end

    // a wrap below zero breaks the match
    assert property (@(posedge clk) disable iff (rst) credit_cnt == held)
        else begin
            fail_cnt++;
            $error("credit count differs from credits returned less words read");
        end

    assert property (@(posedge clk) disable iff (rst) pop |-> (held != '0))
        else begin
            fail_cnt++;
            $error("pop issued with no credit held");
        end

endmodule

bind read_arbiter read_port_assert #(.CRED_W(CRED_W)) u_assert (
    .clk           (clk),
    .rst           (rst),
    .out_valid     (out_valid),
    .out_sop       (out_sop),
    .out_eop       (out_eop),
    .credit_return (credit_return),
    .pop           (rd_en),
    .credit_cnt    (credit_cnt)
);

// File: sim/read_port_tb.sv
// directed testbench for the read port with a reference model and timeout
`timescale 1ns/1ns
`include "read_port_macros.svh"

module read_port_tb;

    localparam int CYCLE_LIMIT = 4000;

    logic                       clk = 1'b0;
    logic                       rst;
    read_port_pkg::sched_mode_e sched_mode;
    logic [`WEIGHT_W-1:0]       wrr_weight;
    logic                       enq_valid;
    read_port_pkg::prio_t       enq_prio;
    read_port_pkg::word_t       enq_data;
    logic                       enq_last;
    logic                       enq_ready;
    logic                       credit_return;
    logic                       out_valid;
    logic                       out_sop;
    logic                       out_eop;
    read_port_pkg::prio_t       out_prio;
    read_port_pkg::word_t       out_data;

    // reference model, expected words and packet lengths per priority
    read_port_pkg::word_t exp_words [`NUM_PRIO][$];
    int                   exp_lens  [`NUM_PRIO][$];
    read_port_pkg::prio_t order_seen[$];
    read_port_pkg::prio_t exp_order[$];
    read_port_pkg::prio_t cur_out;
    int model_cur;
    int model_run;
    int pkt_left;
    int word_idx;
    int words_seen;
    int pkts_seen;
    int sops_seen;
    int eops_seen;
    int word_errs;
    int prio_errs;
    int flag_errs;
    int other_errs;
    int cycle_cnt;
    int total_errs;

    read_port_top dut (
        .clk           (clk),
        .rst           (rst),
        .sched_mode    (sched_mode),
        .wrr_weight    (wrr_weight),
        .enq_valid     (enq_valid),
        .enq_prio      (enq_prio),
        .enq_data      (enq_data),
        .enq_last      (enq_last),
        .enq_ready     (enq_ready),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_sop       (out_sop),
        .out_eop       (out_eop),
        .out_prio      (out_prio),
        .out_data      (out_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_word(input read_port_pkg::word_t got, input read_port_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            word_errs++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_prio(input read_port_pkg::prio_t got, input read_port_pkg::prio_t exp,
                              input string what);
        if (got !== exp) begin
            prio_errs++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        other_errs++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    function automatic int pending_packets();
        int n;
        n = 0;
        for (int i = 0; i < `NUM_PRIO; i++) begin
            n += exp_lens[i].size();
        end
        return n;
    endfunction

    // grant rule of the port: strict priority, or weighted round robin
    task automatic grant_next(output read_port_pkg::prio_t p);
        int weight;
        int idx;
        bit found;
        weight = (wrr_weight == 0) ? 1 : int'(wrr_weight);
        found  = 1'b0;
        p      = '0;
        if (sched_mode == read_port_pkg::sched_sp) begin
            for (int i = `NUM_PRIO - 1; i >= 0; i--) begin
                if (!found && exp_lens[i].size() != 0) begin
                    p     = read_port_pkg::prio_t'(i);
                    found = 1'b1;
                end
            end
        end else if (exp_lens[model_cur].size() != 0 && model_run < weight) begin
            p = read_port_pkg::prio_t'(model_cur);
            model_run++;
        end else begin
            for (int k = 1; k <= `NUM_PRIO; k++) begin
                idx = (model_cur - k + `NUM_PRIO) % `NUM_PRIO;
                if (!found && exp_lens[idx].size() != 0) begin
                    p     = read_port_pkg::prio_t'(idx);
                    found = 1'b1;
                end
            end
            model_cur = int'(p);
            model_run = 1;
        end
    endtask

    // output monitor, outputs are registered so the low phase is stable
    always @(negedge clk) begin
        read_port_pkg::prio_t p;
        if (!rst && out_valid) begin
            if (pkt_left == 0) begin
                if (pending_packets() == 0) begin
                    report_error("output word arrived with no packet pending");
                end else begin
                    grant_next(p);
                    cur_out  = p;
                    pkt_left = exp_lens[p].pop_front();
                    word_idx = 0;
                    order_seen.push_back(out_prio);
                end
            end
            if (pkt_left != 0) begin
                check_prio(out_prio, cur_out, "out_prio");
                check_flag(out_sop, word_idx == 0, "out_sop");
                check_flag(out_eop, pkt_left == 1, "out_eop");
                check_word(out_data, exp_words[cur_out].pop_front(), "out_data");
                sops_seen += int'(out_sop);
                eops_seen += int'(out_eop);
                word_idx++;
                pkt_left--;
                words_seen++;
                if (pkt_left == 0) begin
                    pkts_seen++;
                end
            end
        end
    end

    task automatic reset_dut(input read_port_pkg::sched_mode_e mode, input int weight);
        rst           = 1'b1;
        enq_valid     = 1'b0;
        enq_last      = 1'b0;
        credit_return = 1'b0;
        sched_mode    = mode;
        wrr_weight    = `WEIGHT_W'(weight);
        for (int i = 0; i < `NUM_PRIO; i++) begin
            exp_words[i].delete();
            exp_lens[i].delete();
        end
        order_seen.delete();
        model_cur  = 0;
        model_run  = 0;
        pkt_left   = 0;
        words_seen = 0;
        pkts_seen  = 0;
        sops_seen  = 0;
        eops_seen  = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    // one packet, word by word, valid held until the edge that accepts it
    task automatic send_packet(input read_port_pkg::prio_t prio, input int len);
        read_port_pkg::word_t w;
        for (int i = 0; i < len; i++) begin
            w         = {$urandom, $urandom};
            enq_valid = 1'b1;
            enq_prio  = prio;
            enq_data  = w;
            enq_last  = (i == len - 1);
            do @(posedge clk); while (!enq_ready);
            exp_words[prio].push_back(w);
            @(negedge clk);
        end
        enq_valid = 1'b0;
        enq_last  = 1'b0;
        exp_lens[prio].push_back(len);
    endtask

    // sink frees a slot every cycle until the packets are out
    task automatic drain(input int n_pkts);
        credit_return = 1'b1;
        while (pkts_seen < n_pkts) @(negedge clk);
        credit_return = 1'b0;
    endtask

    task automatic check_order();
        if (order_seen.size() != exp_order.size()) begin
            report_error($sformatf("%0d packets left the port, %0d were expected",
                                   order_seen.size(), exp_order.size()));
        end else begin
            foreach (exp_order[i]) begin
                check_prio(order_seen[i], exp_order[i], "packet order");
            end
        end
    endtask

    task automatic strict_priority_order();
        reset_dut(read_port_pkg::sched_sp, 0);
        send_packet(3'd1, 3);
        send_packet(3'd5, 2);
        send_packet(3'd3, 4);
        repeat (10) @(negedge clk);
        if (words_seen != 0) begin
            report_error("words left the port before any credit was returned");
        end
        drain(3);
        exp_order = {3'd5, 3'd3, 3'd1};
        check_order();
    endtask

    task automatic wrr_weight_order();
        reset_dut(read_port_pkg::sched_wrr, 2);
        for (int i = 0; i < 3; i++) begin
            send_packet(3'd6, i + 2);
            send_packet(3'd2, 3 - i);
        end
        drain(6);
        exp_order = {3'd6, 3'd6, 3'd2, 3'd2, 3'd6, 3'd2};
        check_order();
    endtask

    task automatic packet_framing();
        reset_dut(read_port_pkg::sched_sp, 0);
        send_packet(3'd7, 1);
        send_packet(3'd4, 5);
        send_packet(3'd0, 1);
        send_packet(3'd2, 3);
        drain(4);
        if (words_seen != 10 || sops_seen != 4 || eops_seen != 4) begin
            report_error($sformatf("framing counts words %0d sop %0d eop %0d, expected 10 4 4",
                                   words_seen, sops_seen, eops_seen));
        end
    endtask

    task automatic credit_backpressure();
        int credits;
        credits = 0;
        reset_dut(read_port_pkg::sched_sp, 0);
        send_packet(3'd4, 6);
        send_packet(3'd1, 2);
        repeat (10) @(negedge clk);
        while (pkts_seen < 2) begin
            credit_return = 1'b1;
            @(negedge clk);
            credit_return = 1'b0;
            credits++;
            repeat (3) begin
                @(negedge clk);
                if (words_seen > credits) begin
                    report_error($sformatf("%0d words sent on only %0d credits",
                                           words_seen, credits));
                end
            end
        end
        if (words_seen != 8 || credits != 8) begin
            report_error($sformatf("%0d words on %0d credits, expected 8 on 8",
                                   words_seen, credits));
        end
    endtask

    task automatic region_full_stall();
        reset_dut(read_port_pkg::sched_sp, 0);
        send_packet(3'd3, `PRIO_DEPTH);
        enq_prio = 3'd3;
        @(posedge clk);
        check_flag(enq_ready, 1'b0, "enq_ready on full priority 3");
        @(negedge clk);
        enq_prio = 3'd5;
        @(posedge clk);
        check_flag(enq_ready, 1'b1, "enq_ready on empty priority 5");
        @(negedge clk);
        send_packet(3'd5, 1);
        drain(2);
        exp_order = {3'd5, 3'd3};
        check_order();
    endtask

    initial begin
        rst           = 1'b1;
        sched_mode    = read_port_pkg::sched_sp;
        wrr_weight    = '0;
        enq_valid     = 1'b0;
        enq_prio      = '0;
        enq_data      = '0;
        enq_last      = 1'b0;
        credit_return = 1'b0;
        cycle_cnt     = 0;
        word_errs     = 0;
        prio_errs     = 0;
        flag_errs     = 0;
        other_errs    = 0;
        void'($urandom(35584));
        strict_priority_order();
        wrr_weight_order();
        packet_framing();
        credit_backpressure();
        region_full_stall();
        repeat (5) @(negedge clk);
        total_errs = word_errs + prio_errs + flag_errs + other_errs
                     + dut.u_arbiter.u_assert.fail_cnt;
        $display("Errors: word %0d, prio %0d, flag %0d, other %0d, assertion %0d",
                 word_errs, prio_errs, flag_errs, other_errs,
                 dut.u_arbiter.u_assert.fail_cnt);
        if (total_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
